// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := safe_bus_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(SIM_ARGS) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+common
common/safe_bus_pkg.sv
src/tmr_voter.sv
src/dmr_comparator.sv
src/isolate_responder.sv
safety_mux/safety_mux.sv
src/safe_bus_wrapper.sv
verification/safe_bus_props.sv
verification/safe_bus_tb.sv

// ==== common/safe_bus_consts.svh ====
// Safe bus constants
// Hart count, bus widths, isolation fill words and pair codes shared by the
// lockstep bus path
`ifndef SAFE_BUS_CONSTS_SVH
`define SAFE_BUS_CONSTS_SVH

// Number of harts in the lockstep cluster
`define NHARTS 3

// Bus widths
`define ADDR_W 32
`define DATA_W 32
`define BE_W   4

// Fill words for isolated harts
`define WFI_INSN  32'h10500073
`define DATA_FILL 32'h00000000

// One-hot pair codes for dual comparison
`define PAIR_01 3'b011
`define PAIR_12 3'b110
`define PAIR_02 3'b101

// Hart 0 is master out of reset
`define MASTER_RESET 3'b001

`endif

// ==== common/safe_bus_pkg.sv ====
// Safe bus types
// Request and response structs, operating modes and the configuration word
`default_nettype none

`include "safe_bus_consts.svh"

package safe_bus_pkg;

  // Instruction fetch request
  typedef struct packed {
    logic              req;
    logic [`ADDR_W-1:0] addr;
  } instr_req_t;

  // Load/store request
  typedef struct packed {
    logic              req;
    logic              we;
    logic [`BE_W-1:0]   be;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
  } data_req_t;

  // Memory response, shared by both buses
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [`DATA_W-1:0] rdata;
  } bus_resp_t;

  typedef enum logic [1:0] {
    MODE_INDEP = 2'd0,
    MODE_TMR   = 2'd1,
    MODE_DMR   = 2'd2
  } safe_mode_e;

  // Master is one-hot, pair and wfi use the pair codes
  typedef struct packed {
    safe_mode_e         mode;
    logic [`NHARTS-1:0] master;
    logic [2:0]         dmr_pair;
    logic [2:0]         dmr_wfi;
  } safety_cfg_t;

endpackage

`default_nettype wire

// ==== safety_mux/safety_mux.sv ====
// Safety multiplexer
// Latches the master hart while all harts sleep and routes one bus's
// requests and responses according to the operating mode
`timescale 1ns/1ps
`default_nettype none

`include "safe_bus_consts.svh"

module safety_mux #(
  parameter type req_t = safe_bus_pkg::instr_req_t
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  safe_bus_pkg::safety_cfg_t            cfg_i,
  input  logic [`NHARTS-1:0]                   sleep_i,
  input  req_t [`NHARTS-1:0]                   hart_req_i,
  input  req_t                                 voted_i,
  input  req_t                                 compared_i,
  input  safe_bus_pkg::bus_resp_t [`NHARTS-1:0] iso_resp_i,
  input  safe_bus_pkg::bus_resp_t [`NHARTS-1:0] mem_resp_i,
  output req_t [`NHARTS-1:0]                   mem_req_o,
  output safe_bus_pkg::bus_resp_t [`NHARTS-1:0] hart_resp_o,
  output logic [`NHARTS-1:0]                   iso_req_o,
  input  logic                                 vote_err_i,
  input  logic                                 cmp_err_i,
  output logic                                 tmr_error_o,
  output logic                                 dmr_error_o
);

  import safe_bus_pkg::*;

  logic [`NHARTS-1:0] master_q;
  logic [1:0]         m_idx;
  logic [1:0]         lo_idx;
  logic [1:0]         hi_idx;
  logic [1:0]         third_idx;
  logic [1:0]         p_idx;
  logic               isolate;

  // Master only changes while every hart sleeps
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      master_q <= `MASTER_RESET;
    end else if (sleep_i == '1) begin
      master_q <= cfg_i.master;
    end
  end

  // One-hot master to port index
  always_comb begin
    case (master_q)
      3'b010:  m_idx = 2'd1;
      3'b100:  m_idx = 2'd2;
      default: m_idx = 2'd0;
    endcase
  end

  // Pair members and the free hart
  always_comb begin
    case (cfg_i.dmr_pair)
      `PAIR_12: begin
        lo_idx    = 2'd1;
        hi_idx    = 2'd2;
        third_idx = 2'd0;
      end
      `PAIR_02: begin
        lo_idx    = 2'd0;
        hi_idx    = 2'd2;
        third_idx = 2'd1;
      end
      default: begin
        lo_idx    = 2'd0;
        hi_idx    = 2'd1;
        third_idx = 2'd2;
      end
    endcase
  end

  // Pair uses the master's port when the master belongs to it
  assign p_idx   = cfg_i.dmr_pair[m_idx] ? m_idx : lo_idx;
  assign isolate = (cfg_i.dmr_wfi == cfg_i.dmr_pair);

  // Hart request strobes drive the local grants
  always_comb begin
    for (int i = 0; i < `NHARTS; i++) begin
      iso_req_o[i] = hart_req_i[i].req;
    end
  end

  always_comb begin
    mem_req_o   = '0;
    hart_resp_o = '0;
    tmr_error_o = 1'b0;
    dmr_error_o = 1'b0;
    case (cfg_i.mode)
      MODE_INDEP: begin
        mem_req_o   = hart_req_i;
        hart_resp_o = mem_resp_i;
      end
      MODE_TMR: begin
        mem_req_o[m_idx] = voted_i;
        for (int i = 0; i < `NHARTS; i++) begin
          hart_resp_o[i] = mem_resp_i[m_idx];
        end
        tmr_error_o = vote_err_i;
      end
      MODE_DMR: begin
        // Free hart keeps its own port
        mem_req_o[third_idx]   = hart_req_i[third_idx];
        hart_resp_o[third_idx] = mem_resp_i[third_idx];
        if (isolate) begin
          hart_resp_o[lo_idx] = iso_resp_i[lo_idx];
          hart_resp_o[hi_idx] = iso_resp_i[hi_idx];
        end else begin
          mem_req_o[p_idx]    = compared_i;
          hart_resp_o[lo_idx] = mem_resp_i[p_idx];
          hart_resp_o[hi_idx] = mem_resp_i[p_idx];
        end
        dmr_error_o = cmp_err_i;
      end
      // Reserved encoding parks the bus
      default: begin
        mem_req_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/dmr_comparator.sv ====
// DMR comparator
// Picks the two harts named by the pair code, forwards the lower-index one
// and flags any difference between them
`timescale 1ns/1ps
`default_nettype none

`include "safe_bus_consts.svh"

module dmr_comparator #(
  parameter type req_t = logic
) (
  input  req_t [`NHARTS-1:0] req_i,
  input  logic [2:0]         pair_i,
  output req_t               compared_o,
  output logic               error_o
);

  req_t req_lo;
  req_t req_hi;

  // Pair selection
  always_comb begin
    case (pair_i)
      `PAIR_12: begin
        req_lo = req_i[1];
        req_hi = req_i[2];
      end
      `PAIR_02: begin
        req_lo = req_i[0];
        req_hi = req_i[2];
      end
      // Pair 0/1, also used for unknown codes
      default: begin
        req_lo = req_i[0];
        req_hi = req_i[1];
      end
    endcase
  end

  assign compared_o = req_lo;
  assign error_o    = (req_lo != req_hi);

endmodule

`default_nettype wire

// ==== src/isolate_responder.sv ====
// Isolation responder
// Answers isolated harts locally: grant in the same cycle, rvalid one cycle
// later, read data fixed to a fill word
`timescale 1ns/1ps
`default_nettype none

`include "safe_bus_consts.svh"

module isolate_responder #(
  parameter logic [`DATA_W-1:0] FILL = `DATA_FILL
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [`NHARTS-1:0]                   req_i,
  input  logic                                 clear_i,
  output safe_bus_pkg::bus_resp_t [`NHARTS-1:0] resp_o
);

  logic [`NHARTS-1:0] rvalid_q;

  // Every grant becomes a read-valid on the next edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
    end else if (clear_i) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  always_comb begin
    for (int i = 0; i < `NHARTS; i++) begin
      resp_o[i].gnt    = req_i[i];
      resp_o[i].rvalid = rvalid_q[i];
      resp_o[i].rdata  = FILL;
    end
  end

endmodule

`default_nettype wire

// ==== src/safe_bus_wrapper.sv ====
// Safe bus wrapper
// Lockstep bus path for three harts: voter, comparator, isolation responder
// and safety mux for both the instruction and the data bus
`timescale 1ns/1ps
`default_nettype none

`include "safe_bus_consts.svh"

module safe_bus_wrapper (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  safe_bus_pkg::instr_req_t [`NHARTS-1:0] hart_instr_req_i,
  input  safe_bus_pkg::data_req_t  [`NHARTS-1:0] hart_data_req_i,
  input  safe_bus_pkg::bus_resp_t  [`NHARTS-1:0] mem_instr_resp_i,
  input  safe_bus_pkg::bus_resp_t  [`NHARTS-1:0] mem_data_resp_i,
  input  safe_bus_pkg::safety_cfg_t              cfg_i,
  input  logic [`NHARTS-1:0]                    sleep_i,
  output safe_bus_pkg::instr_req_t [`NHARTS-1:0] mem_instr_req_o,
  output safe_bus_pkg::data_req_t  [`NHARTS-1:0] mem_data_req_o,
  output safe_bus_pkg::bus_resp_t  [`NHARTS-1:0] hart_instr_resp_o,
  output safe_bus_pkg::bus_resp_t  [`NHARTS-1:0] hart_data_resp_o,
  output logic                                  tmr_error_o,
  output logic                                  dmr_error_o
);

  import safe_bus_pkg::*;

  // Instruction bus
  instr_req_t                instr_voted;
  instr_req_t                instr_compared;
  logic                      instr_vote_err;
  logic                      instr_cmp_err;
  bus_resp_t [`NHARTS-1:0]   instr_iso_resp;
  logic [`NHARTS-1:0]        instr_iso_req;
  logic                      instr_tmr_err;
  logic                      instr_dmr_err;

  // Data bus
  data_req_t                 data_voted;
  data_req_t                 data_compared;
  logic                      data_vote_err;
  logic                      data_cmp_err;
  bus_resp_t [`NHARTS-1:0]   data_iso_resp;
  logic [`NHARTS-1:0]        data_iso_req;
  logic                      data_tmr_err;
  logic                      data_dmr_err;

  // Isolated rvalid is dropped whenever no pair is isolated
  logic iso_clear;
  assign iso_clear = (cfg_i.dmr_wfi == 3'b000);

  tmr_voter #(.req_t(instr_req_t)) u_instr_voter (
    .req_i   (hart_instr_req_i),
    .voted_o (instr_voted),
    .error_o (instr_vote_err)
  );

  dmr_comparator #(.req_t(instr_req_t)) u_instr_cmp (
    .req_i      (hart_instr_req_i),
    .pair_i     (cfg_i.dmr_pair),
    .compared_o (instr_compared),
    .error_o    (instr_cmp_err)
  );

  // Isolated harts fetch the sleep instruction
  isolate_responder #(.FILL(`WFI_INSN)) u_instr_iso (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (instr_iso_req),
    .clear_i (iso_clear),
    .resp_o  (instr_iso_resp)
  );

  safety_mux #(.req_t(instr_req_t)) u_instr_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg_i),
    .sleep_i     (sleep_i),
    .hart_req_i  (hart_instr_req_i),
    .voted_i     (instr_voted),
    .compared_i  (instr_compared),
    .iso_resp_i  (instr_iso_resp),
    .mem_resp_i  (mem_instr_resp_i),
    .mem_req_o   (mem_instr_req_o),
    .hart_resp_o (hart_instr_resp_o),
    .iso_req_o   (instr_iso_req),
    .vote_err_i  (instr_vote_err),
    .cmp_err_i   (instr_cmp_err),
    .tmr_error_o (instr_tmr_err),
    .dmr_error_o (instr_dmr_err)
  );

  tmr_voter #(.req_t(data_req_t)) u_data_voter (
    .req_i   (hart_data_req_i),
    .voted_o (data_voted),
    .error_o (data_vote_err)
  );

  dmr_comparator #(.req_t(data_req_t)) u_data_cmp (
    .req_i      (hart_data_req_i),
    .pair_i     (cfg_i.dmr_pair),
    .compared_o (data_compared),
    .error_o    (data_cmp_err)
  );

  // Isolated loads read zero
  isolate_responder #(.FILL(`DATA_FILL)) u_data_iso (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (data_iso_req),
    .clear_i (iso_clear),
    .resp_o  (data_iso_resp)
  );

  safety_mux #(.req_t(data_req_t)) u_data_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg_i),
    .sleep_i     (sleep_i),
    .hart_req_i  (hart_data_req_i),
    .voted_i     (data_voted),
    .compared_i  (data_compared),
    .iso_resp_i  (data_iso_resp),
    .mem_resp_i  (mem_data_resp_i),
    .mem_req_o   (mem_data_req_o),
    .hart_resp_o (hart_data_resp_o),
    .iso_req_o   (data_iso_req),
    .vote_err_i  (data_vote_err),
    .cmp_err_i   (data_cmp_err),
    .tmr_error_o (data_tmr_err),
    .dmr_error_o (data_dmr_err)
  );

  // Either bus can raise a lockstep error
  assign tmr_error_o = instr_tmr_err | data_tmr_err;
  assign dmr_error_o = instr_dmr_err | data_dmr_err;

endmodule

`default_nettype wire

// ==== src/tmr_voter.sv ====
// TMR voter
// Bitwise majority of three hart requests, with a flag when they disagree
`timescale 1ns/1ps
`default_nettype none

`include "safe_bus_consts.svh"

module tmr_voter #(
  parameter type req_t = logic
) (
  input  req_t [`NHARTS-1:0] req_i,
  output req_t               voted_o,
  output logic               error_o
);

  req_t agree_01;
  req_t agree_12;
  req_t agree_02;

  // Bits on which each pair of harts agrees on a one
  assign agree_01 = req_i[0] & req_i[1];
  assign agree_12 = req_i[1] & req_i[2];
  assign agree_02 = req_i[0] & req_i[2];

  // Any two ones win the bit
  assign voted_o = agree_01 | agree_12 | agree_02;

  // A single corrupted hart still votes correctly but is reported
  assign error_o = (req_i[0] != req_i[1]) || (req_i[1] != req_i[2]);

endmodule

`default_nettype wire

// ==== verification/safe_bus_props.sv ====
// Safety mux properties
// One-hot master, idle ports in TMR mode and isolated read-valid timing
`timescale 1ns/1ps
`default_nettype none

`include "safe_bus_consts.svh"

module safe_bus_props (
  input logic                     clk_i,
  input logic                     rst_ni,
  input safe_bus_pkg::safe_mode_e mode_i,
  input logic [`NHARTS-1:0]       master_i,
  input logic [`NHARTS-1:0]       port_busy_i,
  input logic [`NHARTS-1:0]       iso_req_i,
  input logic [`NHARTS-1:0]       iso_rvalid_i,
  input logic [2:0]               wfi_i
);

  import safe_bus_pkg::*;

  int unsigned fail_count = 0;

  master_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot(master_i)
  ) else begin
    $error("Master latch is not one-hot");
    fail_count++;
  end

  // Only the master port is driven while voting
  tmr_idle_ports: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mode_i == MODE_TMR) |-> ((port_busy_i & ~master_i) == '0)
  ) else begin
    $error("Non-master port carries a request in TMR mode");
    fail_count++;
  end

  iso_rvalid_follows: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (wfi_i != 3'b000) |=> (iso_rvalid_i == $past(iso_req_i))
  ) else begin
    $error("Isolated rvalid does not follow the previous grant");
    fail_count++;
  end

endmodule

bind safety_mux safe_bus_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .mode_i       (cfg_i.mode),
  .master_i     (master_q),
  .port_busy_i  ({|mem_req_o[2], |mem_req_o[1], |mem_req_o[0]}),
  .iso_req_i    (iso_req_o),
  .iso_rvalid_i ({iso_resp_i[2].rvalid, iso_resp_i[1].rvalid, iso_resp_i[0].rvalid}),
  .wfi_i        (cfg_i.dmr_wfi)
);

`default_nettype wire

// ==== verification/safe_bus_tb.sv ====
// Safe bus testbench
// Random stimulus in all three modes, checked cycle by cycle against a
// reference model of the routing rules
`timescale 1ns/1ps
`default_nettype none

`include "safe_bus_consts.svh"

module safe_bus_tb;

  import safe_bus_pkg::*;

  localparam int INDEP_CYC  = 40;
  localparam int TMR_CYC    = 60;
  localparam int LATCH_CYC  = 8;
  // Per pair code
  localparam int DMR_CYC    = 30;
  localparam int ISO_CYC    = 20;
  localparam int MAX_CYCLES = 3 + INDEP_CYC + TMR_CYC + LATCH_CYC + 3 * DMR_CYC
                              + 3 * (ISO_CYC + 2) + 50;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  instr_req_t [`NHARTS-1:0] hart_instr_req;
  data_req_t  [`NHARTS-1:0] hart_data_req;
  bus_resp_t  [`NHARTS-1:0] mem_instr_resp;
  bus_resp_t  [`NHARTS-1:0] mem_data_resp;
  safety_cfg_t              cfg;
  logic [`NHARTS-1:0]       sleep;
  instr_req_t [`NHARTS-1:0] mem_instr_req;
  data_req_t  [`NHARTS-1:0] mem_data_req;
  bus_resp_t  [`NHARTS-1:0] hart_instr_resp;
  bus_resp_t  [`NHARTS-1:0] hart_data_resp;
  logic                     tmr_error;
  logic                     dmr_error;

  // Reference model state
  logic [`NHARTS-1:0] model_master;
  logic [`NHARTS-1:0] model_irv;
  logic [`NHARTS-1:0] model_drv;

  int checks = 0;
  int errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  int cycle_cnt = 0;

  safe_bus_wrapper u_safe_bus_wrapper (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .hart_instr_req_i  (hart_instr_req),
    .hart_data_req_i   (hart_data_req),
    .mem_instr_resp_i  (mem_instr_resp),
    .mem_data_resp_i   (mem_data_resp),
    .cfg_i             (cfg),
    .sleep_i           (sleep),
    .mem_instr_req_o   (mem_instr_req),
    .mem_data_req_o    (mem_data_req),
    .hart_instr_resp_o (hart_instr_resp),
    .hart_data_resp_o  (hart_data_resp),
    .tmr_error_o       (tmr_error),
    .dmr_error_o       (dmr_error)
  );

  always #20 clk_i = ~clk_i;

  // Run limit from the summed test lengths
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic note_check(bit ok);
    checks++;
    test_checks++;
    if (!ok) begin
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_instr_req(string name, instr_req_t got, instr_req_t exp);
    note_check(got === exp);
    if (got !== exp) $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic check_data_req(string name, data_req_t got, data_req_t exp);
    note_check(got === exp);
    if (got !== exp) $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic check_resp(string name, bus_resp_t got, bus_resp_t exp);
    note_check(got === exp);
    if (got !== exp) $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    note_check(got === exp);
    if (got !== exp) $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
  endtask

  function automatic instr_req_t rand_instr();
    logic [31:0] w0;
    logic [31:0] w1;
    w0 = $urandom();
    w1 = $urandom();
    return {w0[0], w1};
  endfunction

  function automatic data_req_t rand_data();
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    w0 = $urandom();
    w1 = $urandom();
    w2 = $urandom();
    return {w0[0], w0[1], w0[5:2], w1, w2};
  endfunction

  function automatic bus_resp_t rand_resp();
    logic [31:0] w0;
    logic [31:0] w1;
    w0 = $urandom();
    w1 = $urandom();
    return {w0[0], w0[1], w1};
  endfunction

  function automatic bit coin();
    logic [31:0] w;
    w = $urandom();
    return w[0];
  endfunction

  // Any sleep pattern except all harts asleep
  function automatic logic [2:0] rand_sleep();
    logic [31:0] w;
    w = $urandom();
    return (w[2:0] == 3'b111) ? 3'b011 : w[2:0];
  endfunction

  function automatic safety_cfg_t make_cfg(safe_mode_e mode, logic [2:0] master,
                                           logic [2:0] pair, logic [2:0] wfi);
    safety_cfg_t c;
    c.mode     = mode;
    c.master   = master;
    c.dmr_pair = pair;
    c.dmr_wfi  = wfi;
    return c;
  endfunction

  // Bit counting majority of three requests
  function automatic instr_req_t vote_instr(instr_req_t a, instr_req_t b, instr_req_t c);
    instr_req_t r;
    int n;
    for (int k = 0; k < $bits(instr_req_t); k++) begin
      n = int'(a[k]) + int'(b[k]) + int'(c[k]);
      r[k] = (n >= 2);
    end
    return r;
  endfunction

  function automatic data_req_t vote_data(data_req_t a, data_req_t b, data_req_t c);
    data_req_t r;
    int n;
    for (int k = 0; k < $bits(data_req_t); k++) begin
      n = int'(a[k]) + int'(b[k]) + int'(c[k]);
      r[k] = (n >= 2);
    end
    return r;
  endfunction

  function automatic bus_resp_t iso_resp(logic req, logic rv, logic [`DATA_W-1:0] fill);
    bus_resp_t r;
    r.gnt    = req;
    r.rvalid = rv;
    r.rdata  = fill;
    return r;
  endfunction

  // Expected outputs for the current inputs, then the model's next state
  task automatic check_outputs();
    instr_req_t [`NHARTS-1:0] exp_ireq;
    data_req_t  [`NHARTS-1:0] exp_dreq;
    bus_resp_t  [`NHARTS-1:0] exp_iresp;
    bus_resp_t  [`NHARTS-1:0] exp_dresp;
    logic exp_tmr;
    logic exp_dmr;
    int m;
    int lo;
    int hi;
    int third;
    int p;
    exp_ireq  = '0;
    exp_dreq  = '0;
    exp_iresp = '0;
    exp_dresp = '0;
    exp_tmr   = 1'b0;
    exp_dmr   = 1'b0;
    m     = 0;
    lo    = -1;
    hi    = 0;
    third = 0;
    for (int i = 0; i < `NHARTS; i++) begin
      if (model_master[i]) m = i;
      if (!cfg.dmr_pair[i]) third = i;
      else if (lo < 0) lo = i;
      else hi = i;
    end
    p = cfg.dmr_pair[m] ? m : lo;
    case (cfg.mode)
      MODE_INDEP: begin
        exp_ireq  = hart_instr_req;
        exp_dreq  = hart_data_req;
        exp_iresp = mem_instr_resp;
        exp_dresp = mem_data_resp;
      end
      MODE_TMR: begin
        exp_ireq[m] = vote_instr(hart_instr_req[0], hart_instr_req[1], hart_instr_req[2]);
        exp_dreq[m] = vote_data(hart_data_req[0], hart_data_req[1], hart_data_req[2]);
        for (int i = 0; i < `NHARTS; i++) begin
          exp_iresp[i] = mem_instr_resp[m];
          exp_dresp[i] = mem_data_resp[m];
        end
        exp_tmr = !((hart_instr_req[0] == hart_instr_req[1])
                    && (hart_instr_req[1] == hart_instr_req[2])
                    && (hart_data_req[0] == hart_data_req[1])
                    && (hart_data_req[1] == hart_data_req[2]));
      end
      MODE_DMR: begin
        exp_ireq[third]  = hart_instr_req[third];
        exp_dreq[third]  = hart_data_req[third];
        exp_iresp[third] = mem_instr_resp[third];
        exp_dresp[third] = mem_data_resp[third];
        if (cfg.dmr_wfi == cfg.dmr_pair) begin
          exp_iresp[lo] = iso_resp(hart_instr_req[lo].req, model_irv[lo], `WFI_INSN);
          exp_iresp[hi] = iso_resp(hart_instr_req[hi].req, model_irv[hi], `WFI_INSN);
          exp_dresp[lo] = iso_resp(hart_data_req[lo].req, model_drv[lo], `DATA_FILL);
          exp_dresp[hi] = iso_resp(hart_data_req[hi].req, model_drv[hi], `DATA_FILL);
        end else begin
          exp_ireq[p]   = hart_instr_req[lo];
          exp_dreq[p]   = hart_data_req[lo];
          exp_iresp[lo] = mem_instr_resp[p];
          exp_iresp[hi] = mem_instr_resp[p];
          exp_dresp[lo] = mem_data_resp[p];
          exp_dresp[hi] = mem_data_resp[p];
        end
        exp_dmr = (hart_instr_req[lo] != hart_instr_req[hi])
                  || (hart_data_req[lo] != hart_data_req[hi]);
      end
      default: begin
      end
    endcase
    for (int i = 0; i < `NHARTS; i++) begin
      check_instr_req($sformatf("mem_instr_req_o[%0d]", i), mem_instr_req[i], exp_ireq[i]);
      check_data_req($sformatf("mem_data_req_o[%0d]", i), mem_data_req[i], exp_dreq[i]);
      check_resp($sformatf("hart_instr_resp_o[%0d]", i), hart_instr_resp[i], exp_iresp[i]);
      check_resp($sformatf("hart_data_resp_o[%0d]", i), hart_data_resp[i], exp_dresp[i]);
    end
    check_flag("tmr_error_o", tmr_error, exp_tmr);
    check_flag("dmr_error_o", dmr_error, exp_dmr);
    // State for the next cycle
    if (sleep == 3'b111) model_master = cfg.master;
    for (int i = 0; i < `NHARTS; i++) begin
      model_irv[i] = (cfg.dmr_wfi != 3'b000) && hart_instr_req[i].req;
      model_drv[i] = (cfg.dmr_wfi != 3'b000) && hart_data_req[i].req;
    end
  endtask

  // One cycle: new inputs on the rising edge, check on the falling edge
  task automatic drive_cycle(safety_cfg_t c, logic [2:0] sl, bit same, bit corrupt);
    instr_req_t bi;
    data_req_t  bd;
    int         h;
    bit         on_instr;
    bi       = rand_instr();
    bd       = rand_data();
    h        = $urandom_range(0, 2);
    on_instr = coin();
    @(posedge clk_i);
    cfg   <= c;
    sleep <= sl;
    for (int i = 0; i < `NHARTS; i++) begin
      hart_instr_req[i] <= same ? bi : rand_instr();
      hart_data_req[i]  <= same ? bd : rand_data();
      mem_instr_resp[i] <= rand_resp();
      mem_data_resp[i]  <= rand_resp();
    end
    if (same && corrupt) begin
      if (on_instr) hart_instr_req[h] <= rand_instr();
      else hart_data_req[h] <= rand_data();
    end
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic start_test();
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test(string name);
    $display("Test %-12s %0d checks, %0d mismatches", name, test_checks, test_errors);
  endtask

  initial begin
    logic [2:0]  pairs [3];
    logic [2:0]  new_master;
    safety_cfg_t c;
    void'($urandom(19));
    pairs = '{`PAIR_01, `PAIR_12, `PAIR_02};
    rst_ni         = 1'b0;
    cfg            = make_cfg(MODE_INDEP, `MASTER_RESET, `PAIR_01, 3'b000);
    sleep          = '0;
    hart_instr_req = '0;
    hart_data_req  = '0;
    mem_instr_resp = '0;
    mem_data_resp  = '0;
    model_master   = `MASTER_RESET;
    model_irv      = '0;
    model_drv      = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test();
    repeat (INDEP_CYC) begin
      drive_cycle(make_cfg(MODE_INDEP, model_master, `PAIR_01, 3'b000), rand_sleep(), 0, 0);
    end
    end_test("independent");

    start_test();
    repeat (TMR_CYC) begin
      drive_cycle(make_cfg(MODE_TMR, model_master, `PAIR_01, 3'b000), rand_sleep(), 1, coin());
    end
    end_test("tmr");

    // New master waits for a cycle with every hart asleep
    start_test();
    new_master = {model_master[1:0], model_master[2]};
    c = make_cfg(MODE_TMR, new_master, `PAIR_01, 3'b000);
    repeat (4) drive_cycle(c, rand_sleep(), 1, coin());
    drive_cycle(c, 3'b111, 1, 0);
    repeat (3) drive_cycle(c, rand_sleep(), 1, coin());
    end_test("master_latch");

    start_test();
    for (int k = 0; k < 3; k++) begin
      repeat (DMR_CYC) begin
        drive_cycle(make_cfg(MODE_DMR, model_master, pairs[k], 3'b000), rand_sleep(), 1, coin());
      end
    end
    end_test("dmr");

    // Isolation, then a cycle with wfi cleared, then isolation again
    start_test();
    for (int k = 0; k < 3; k++) begin
      c = make_cfg(MODE_DMR, model_master, pairs[k], pairs[k]);
      repeat (ISO_CYC) drive_cycle(c, rand_sleep(), 0, 0);
      drive_cycle(make_cfg(MODE_DMR, model_master, pairs[k], 3'b000), rand_sleep(), 0, 0);
      drive_cycle(c, rand_sleep(), 0, 0);
    end
    end_test("isolation");

    if (u_safe_bus_wrapper.u_instr_mux.u_props.fail_count != 0
        || u_safe_bus_wrapper.u_data_mux.u_props.fail_count != 0) begin
      $display("An assertion in the safety mux failed");
      errors++;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
